// File: hdl/coco_glue_pkg.sv
/* Shared widths, option bit positions, machine codes and tape thresholds
   for the CoCo2 / Dragon host glue. Imported by every RTL block. */
`default_nettype none

package coco_glue_pkg;

	////////////////////////////////////////
	// Data widths
	////////////////////////////////////////

	// Host option word from the menu
	localparam int STATUS_W = 32;

	// One ADC conversion
	localparam int ADC_W = 12;

	// Running average window of 512 samples
	localparam int AVG_LOG2 = 9;
	localparam int AVG_DEPTH = 1 << AVG_LOG2;
	// Sum of a full window, no overflow at full scale
	localparam int AVG_TOTAL_W = ADC_W + AVG_LOG2;

	// Tape slicer distance from the average, about 0.1 V
	localparam int TAPE_HYST = 100;

	// Core sound in, host sample out
	localparam int SND_W = 12;
	localparam int AUDIO_W = 16;

	// Digital joystick word and analog X/Y pair
	localparam int JOY_W = 32;
	localparam int AJOY_W = 16;

	////////////////////////////////////////
	// Reset control
	////////////////////////////////////////

	// Core reset length after a machine change
	localparam int RESET_HOLD = 15;

	// Download index of the system ROM
	localparam logic [7:0] ROM_INDEX = 8'd1;

	////////////////////////////////////////
	// Status word bit positions
	////////////////////////////////////////

	localparam int ST_RESET = 0;
	localparam int ST_ART_PHASE = 2;
	localparam int ST_ART_OFF = 3;
	localparam int ST_OVERSCAN = 4;
	localparam int ST_TURBO = 7;
	// Two bit field
	localparam int ST_MACHINE = 8;
	localparam int ST_SWAP = 10;
	localparam int ST_TAPE_ADC = 12;
	localparam int ST_TAPE_MON = 13;
	localparam int ST_DISK = 14;
	// Three bit field
	localparam int ST_SCALE = 15;
	// Two bit field
	localparam int ST_AR = 19;
	localparam int ST_DPAD = 21;
	localparam int ST_KB_COCO = 22;
	localparam int ST_HARD_RESET = 23;

	// Machine menu codes, code 3 behaves as Dragon32
	typedef enum logic [1:0] {
		COCO2    = 2'd0,
		DRAGON32 = 2'd1,
		DRAGON64 = 2'd2
	} machine_t;

endpackage

`default_nettype wire

// File: hdl/adc_tape_detector.sv
/* Cassette input from the ADC. Picks up each new sample from the sync toggle,
   keeps a 512-sample running average and slices the tape bit with hysteresis. */
`timescale 1ns/1ps
`default_nettype none

module adc_tape_detector
	import coco_glue_pkg::*;
(
	input  logic             clk_sys,
	input  logic             i_reset,
	input  logic [ADC_W-1:0] i_adc_data,
	input  logic             i_adc_sync,
	output logic [ADC_W-1:0] o_adc_value,
	output logic [ADC_W-1:0] o_adc_avg,
	output logic             o_tape_bit
);

	// Hysteresis at the widened compare width
	localparam logic [ADC_W:0] HYST = (ADC_W + 1)'(TAPE_HYST);

	logic                   sync_q;
	logic                   sample_edge;
	logic [ADC_W-1:0]       window_mem [AVG_DEPTH];
	logic [AVG_LOG2-1:0]    wr_ptr;
	logic [AVG_LOG2:0]      sample_cnt;
	logic                   window_full;
	logic [ADC_W-1:0]       oldest_q;
	logic [AVG_TOTAL_W-1:0] leaving;
	logic [AVG_TOTAL_W-1:0] adc_total;
	logic [ADC_W-1:0]       new_avg;
	logic                   upd_total;
	logic                   upd_avg;

	// Any level change of the toggle is a new sample
	assign sample_edge = i_adc_sync ^ sync_q;

	// Top count bit set once 512 samples are in
	assign window_full = sample_cnt[AVG_LOG2];

	// Oldest entry only counts once the window has filled
	assign leaving = window_full ? AVG_TOTAL_W'(oldest_q) : '0;

	// Divide by 512
	assign new_avg = adc_total[AVG_TOTAL_W-1 -: ADC_W];

	////////////////////////////////////////
	// Sample latch and window memory
	////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (sample_edge)
		begin
			o_adc_value <= i_adc_data;
			// Slot under the pointer is the sample about to leave
			oldest_q <= window_mem[wr_ptr];
		end
		if (upd_total)
			window_mem[wr_ptr] <= o_adc_value;
	end

	////////////////////////////////////////
	// Average and tape slicer
	////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			// Follow the toggle so reset release gives no false sample
			sync_q <= i_adc_sync;
			upd_total <= 1'b0;
			upd_avg <= 1'b0;
			wr_ptr <= '0;
			sample_cnt <= '0;
			adc_total <= '0;
			o_adc_avg <= '0;
			o_tape_bit <= 1'b0;
		end
		else
		begin
			sync_q <= i_adc_sync;
			upd_total <= sample_edge;
			upd_avg <= upd_total;

			// Stage 1, add the new sample and drop the oldest
			if (upd_total)
			begin
				adc_total <= adc_total + AVG_TOTAL_W'(o_adc_value) - leaving;
				wr_ptr <= wr_ptr + 1'b1;
				if (!window_full)
					sample_cnt <= sample_cnt + 1'b1;
			end

			// Stage 2, publish the average and compare against it
			if (upd_avg)
			begin
				o_adc_avg <= new_avg;
				// Low input gives a 1, the inverted sense of the real machine
				if (({1'b0, o_adc_value} + HYST) < {1'b0, new_avg})
					o_tape_bit <= 1'b1;
				else if ({1'b0, o_adc_value} > ({1'b0, new_avg} + HYST))
					o_tape_bit <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/machine_config.sv
/* Machine option registers and reset sequencing for the core. Combines all
   reset sources and decodes the aspect ratio and scanline menu options. */
`timescale 1ns/1ps
`default_nettype none

module machine_config
	import coco_glue_pkg::*;
(
	input  logic        clk_sys,
	input  logic        i_reset,
	input  logic        i_reset_req,
	input  logic        i_button_reset,
	input  logic        i_ioctl_download,
	input  logic [7:0]  i_ioctl_index,
	input  machine_t    i_machine,
	input  logic        i_hard_req,
	input  logic        i_disk_sel,
	input  logic [2:0]  i_scale,
	input  logic [1:0]  i_ar,
	input  logic        i_forced_scandoubler,
	output logic        o_core_reset,
	output logic        o_hard_reset,
	output logic        o_dragon,
	output logic        o_dragon64,
	output logic        o_disk_cart,
	output logic [12:0] o_video_arx,
	output logic [12:0] o_video_ary,
	output logic [1:0]  o_vga_sl,
	output logic        o_hq2x,
	output logic        o_scandoubler
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	// Hard reset pulse sequencer
	typedef enum logic [1:0] {
		HR_IDLE,
		HR_ARM,
		HR_PULSE
	} hr_state_t;

	machine_t          machine_q;
	logic              hard_req_q;
	logic              machine_change;
	logic              hard_change;
	logic [HOLD_W-1:0] hold_cnt;
	logic              hold_reset;
	hr_state_t         hr_state;
	logic              rom_load;
	logic [2:0]        sl_full;

	assign machine_change = (i_machine != machine_q);
	assign hard_change = (i_hard_req != hard_req_q);

	// ROM reload keeps the core in reset
	assign rom_load = i_ioctl_download && (i_ioctl_index == ROM_INDEX);

	// Straight OR, no register on the way to the core
	assign o_core_reset = i_reset | i_reset_req | i_button_reset | rom_load | hold_reset;

	assign o_hard_reset = (hr_state == HR_PULSE);

	// Scale 0 is no filter, 1 is hq2x, then the scanline levels
	assign sl_full = (i_scale != 3'd0) ? (i_scale - 3'd1) : 3'd0;

	////////////////////////////////////////
	// Reset sequencing
	////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			// Start from the current options so reset itself changes nothing
			machine_q <= i_machine;
			hard_req_q <= i_hard_req;
			hold_cnt <= '0;
			hold_reset <= 1'b0;
			hr_state <= HR_IDLE;
		end
		else
		begin
			machine_q <= i_machine;
			hard_req_q <= i_hard_req;

			// A fresh change restarts the hold
			if (machine_change || hard_change)
				hold_cnt <= HOLD_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			hold_reset <= (hold_cnt != '0);

			case (hr_state)
				HR_IDLE:
					if (hard_change)
						hr_state <= HR_ARM;
				HR_ARM:
					hr_state <= HR_PULSE;
				HR_PULSE:
					// Back to back toggles still leave a low cycle between pulses
					hr_state <= hard_change ? HR_ARM : HR_IDLE;
				default:
					hr_state <= HR_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Registered options
	////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		o_dragon <= (i_machine != COCO2);
		o_dragon64 <= (i_machine == DRAGON64);
		o_disk_cart <= i_disk_sel;

		// Original 4:3, else the host aspect code
		o_video_arx <= (i_ar == 2'd0) ? 13'd4 : (13'(i_ar) - 13'd1);
		o_video_ary <= (i_ar == 2'd0) ? 13'd3 : 13'd0;

		o_vga_sl <= sl_full[1:0];
		o_hq2x <= (i_scale == 3'd1);
		o_scandoubler <= (i_scale != 3'd0) || i_forced_scandoubler;
	end

endmodule

`default_nettype wire

// File: hdl/tape_audio_mixer.sv
/* Tape source select for the core and the mono audio packer.
   The 16-bit sample goes out on both host channels. */
`timescale 1ns/1ps
`default_nettype none

module tape_audio_mixer
	import coco_glue_pkg::*;
(
	input  logic               i_tape_adc_sel,
	input  logic               i_tape_monitor,
	input  logic               i_adc_bit,
	input  logic               i_player_bit,
	input  logic [SND_W-1:0]   i_core_sound,
	input  logic               i_core_sndout,
	output logic               o_cas_to_core,
	output logic [AUDIO_W-1:0] o_audio_l,
	output logic [AUDIO_W-1:0] o_audio_r
);

	logic monitor_bit;

	// ADC input or the tape file player
	assign o_cas_to_core = i_tape_adc_sel ? i_adc_bit : i_player_bit;

	// Tape heard only when monitoring is on
	assign monitor_bit = i_tape_monitor & o_cas_to_core;

	// 1-bit sound loudest, then the 12-bit DAC
	// Monitor bit folded in low so it stays quiet
	assign o_audio_l = {
		i_core_sndout,
		i_core_sound[SND_W-1:6],
		i_core_sound[5] ^ monitor_bit,
		i_core_sound[4:0],
		3'b000
	};

	// Mono machine
	assign o_audio_r = o_audio_l;

endmodule

`default_nettype wire

// File: hdl/joystick_router.sv
/* Joystick routing to the core. Centres each analog axis at 128
   and swaps the two players when asked. */
`timescale 1ns/1ps
`default_nettype none

module joystick_router
	import coco_glue_pkg::*;
(
	input  logic              i_swap,
	input  logic [JOY_W-1:0]  i_joy1,
	input  logic [JOY_W-1:0]  i_joy2,
	input  logic [AJOY_W-1:0] i_ajoy1,
	input  logic [AJOY_W-1:0] i_ajoy2,
	output logic [JOY_W-1:0]  o_joy1,
	output logic [JOY_W-1:0]  o_joy2,
	output logic [AJOY_W-1:0] o_ajoy1,
	output logic [AJOY_W-1:0] o_ajoy2
);

	logic [AJOY_W-1:0] centred1;
	logic [AJOY_W-1:0] centred2;

	// Signed stick to offset-128, byte order kept
	function automatic logic [AJOY_W-1:0] centre_pair(input logic [AJOY_W-1:0] pair);
		logic [7:0] axis_x;
		logic [7:0] axis_y;
		axis_x = pair[15:8] + 8'd128;
		axis_y = pair[7:0] + 8'd128;
		return {axis_x, axis_y};
	endfunction

	assign centred1 = centre_pair(i_ajoy1);
	assign centred2 = centre_pair(i_ajoy2);

	////////////////////////////////////////
	// Player swap
	////////////////////////////////////////

	// Digital and analog move together
	assign o_joy1 = i_swap ? i_joy2 : i_joy1;
	assign o_joy2 = i_swap ? i_joy1 : i_joy2;
	assign o_ajoy1 = i_swap ? centred2 : centred1;
	assign o_ajoy2 = i_swap ? centred1 : centred2;

endmodule

`default_nettype wire

// File: hdl/coco_glue_top.sv
/* Glue between the host platform and the CoCo2 / Dragon core.
   Splits the status word into option fields and wires up the four blocks. */
`timescale 1ns/1ps
`default_nettype none

module coco_glue_top
	import coco_glue_pkg::*;
(
	input  logic                clk_sys,
	input  logic                i_reset,
	input  logic [STATUS_W-1:0] i_status,
	input  logic                i_button_reset,
	input  logic                i_ioctl_download,
	input  logic [7:0]          i_ioctl_index,
	input  logic                i_forced_scandoubler,
	input  logic [ADC_W-1:0]    i_adc_data,
	input  logic                i_adc_sync,
	input  logic                i_player_bit,
	input  logic [SND_W-1:0]    i_core_sound,
	input  logic                i_core_sndout,
	input  logic [JOY_W-1:0]    i_joy1,
	input  logic [JOY_W-1:0]    i_joy2,
	input  logic [AJOY_W-1:0]   i_ajoy1,
	input  logic [AJOY_W-1:0]   i_ajoy2,
	output logic                o_core_reset,
	output logic                o_hard_reset,
	output logic                o_dragon,
	output logic                o_dragon64,
	output logic                o_disk_cart,
	output logic                o_turbo,
	output logic                o_kb_coco,
	output logic                o_artifact_phase,
	output logic                o_artifact_en,
	output logic                o_overscan,
	output logic                o_dpad,
	output logic                o_cas_to_core,
	output logic [ADC_W-1:0]    o_adc_value,
	output logic [AUDIO_W-1:0]  o_audio_l,
	output logic [AUDIO_W-1:0]  o_audio_r,
	output logic [12:0]         o_video_arx,
	output logic [12:0]         o_video_ary,
	output logic [1:0]          o_vga_sl,
	output logic                o_hq2x,
	output logic                o_scandoubler,
	output logic [JOY_W-1:0]    o_joy1,
	output logic [JOY_W-1:0]    o_joy2,
	output logic [AJOY_W-1:0]   o_ajoy1,
	output logic [AJOY_W-1:0]   o_ajoy2
);

	logic     adc_bit;
	machine_t status_machine;

	assign status_machine = machine_t'(i_status[ST_MACHINE +: 2]);

	// Direct menu flags
	assign o_turbo = i_status[ST_TURBO];
	assign o_kb_coco = i_status[ST_KB_COCO];
	assign o_artifact_phase = i_status[ST_ART_PHASE];
	// Menu bit means artifact off
	assign o_artifact_en = ~i_status[ST_ART_OFF];
	assign o_overscan = i_status[ST_OVERSCAN];
	assign o_dpad = i_status[ST_DPAD];

	adc_tape_detector u_adc_tape (
		.clk_sys     (clk_sys),
		.i_reset     (i_reset),
		.i_adc_data  (i_adc_data),
		.i_adc_sync  (i_adc_sync),
		.o_adc_value (o_adc_value),
		.o_adc_avg   (),
		.o_tape_bit  (adc_bit)
	);

	machine_config u_machine_config (
		.clk_sys              (clk_sys),
		.i_reset              (i_reset),
		.i_reset_req          (i_status[ST_RESET]),
		.i_button_reset       (i_button_reset),
		.i_ioctl_download     (i_ioctl_download),
		.i_ioctl_index        (i_ioctl_index),
		.i_machine            (status_machine),
		.i_hard_req           (i_status[ST_HARD_RESET]),
		.i_disk_sel           (i_status[ST_DISK]),
		.i_scale              (i_status[ST_SCALE +: 3]),
		.i_ar                 (i_status[ST_AR +: 2]),
		.i_forced_scandoubler (i_forced_scandoubler),
		.o_core_reset         (o_core_reset),
		.o_hard_reset         (o_hard_reset),
		.o_dragon             (o_dragon),
		.o_dragon64           (o_dragon64),
		.o_disk_cart          (o_disk_cart),
		.o_video_arx          (o_video_arx),
		.o_video_ary          (o_video_ary),
		.o_vga_sl             (o_vga_sl),
		.o_hq2x               (o_hq2x),
		.o_scandoubler        (o_scandoubler)
	);

	tape_audio_mixer u_tape_audio (
		.i_tape_adc_sel (i_status[ST_TAPE_ADC]),
		.i_tape_monitor (i_status[ST_TAPE_MON]),
		.i_adc_bit      (adc_bit),
		.i_player_bit   (i_player_bit),
		.i_core_sound   (i_core_sound),
		.i_core_sndout  (i_core_sndout),
		.o_cas_to_core  (o_cas_to_core),
		.o_audio_l      (o_audio_l),
		.o_audio_r      (o_audio_r)
	);

	joystick_router u_joystick (
		.i_swap  (i_status[ST_SWAP]),
		.i_joy1  (i_joy1),
		.i_joy2  (i_joy2),
		.i_ajoy1 (i_ajoy1),
		.i_ajoy2 (i_ajoy2),
		.o_joy1  (o_joy1),
		.o_joy2  (o_joy2),
		.o_ajoy1 (o_ajoy1),
		.o_ajoy2 (o_ajoy2)
	);

endmodule

`default_nettype wire

// File: test/coco_glue_checker.sv
/* Concurrent timing checks on the machine option and reset sequencer.
   Bound into machine_config at the end of this file. */
`timescale 1ns/1ps
`default_nettype none

module coco_glue_checker
	import coco_glue_pkg::*;
(
	input  logic     clk_sys,
	input  logic     i_reset,
	input  machine_t i_machine,
	input  logic     o_core_reset,
	input  logic     o_hard_reset
);

	machine_t            machine_q;
	// Bit n set when the machine field changed n+1 edges ago
	logic [RESET_HOLD:0] change_hist;

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			machine_q <= i_machine;
			change_hist <= '0;
		end
		else
		begin
			machine_q <= i_machine;
			change_hist <= {change_hist[RESET_HOLD-1:0], (i_machine != machine_q)};
		end
	end

	////////////////////////////////////////
	// Reset sequencer properties
	////////////////////////////////////////

	// Hard reset is a single cycle strobe
	hard_pulse_single: assert property (@(posedge clk_sys) disable iff (i_reset)
		o_hard_reset |=> !o_hard_reset)
		else $error("o_hard_reset held high for two cycles");

	// Core reset covers the whole hold window after a machine change
	core_reset_hold: assert property (@(posedge clk_sys) disable iff (i_reset)
		(|change_hist[RESET_HOLD:1]) |-> o_core_reset)
		else $error("o_core_reset dropped inside the machine change hold");

	// Reset leaves the hard reset strobe idle
	hard_reset_idle: assert property (@(posedge clk_sys)
		i_reset |=> !o_hard_reset)
		else $error("o_hard_reset high right after reset");

endmodule

bind machine_config coco_glue_checker u_checker (
	.clk_sys      (clk_sys),
	.i_reset      (i_reset),
	.i_machine    (i_machine),
	.o_core_reset (o_core_reset),
	.o_hard_reset (o_hard_reset)
);

`default_nettype wire

// File: test/coco_glue_tb.sv
/* Testbench for the CoCo2 / Dragon host glue. Drives the top level through
   machine select, reset sources, tape slicing, audio, joysticks and video. */
`timescale 1ns/1ps
`default_nettype none

module coco_glue_tb
	import coco_glue_pkg::*;
;

	logic                clk_sys;
	logic                i_reset;
	logic [STATUS_W-1:0] i_status;
	logic                i_button_reset;
	logic                i_ioctl_download;
	logic [7:0]          i_ioctl_index;
	logic                i_forced_scandoubler;
	logic [ADC_W-1:0]    i_adc_data;
	logic                i_adc_sync;
	logic                i_player_bit;
	logic [SND_W-1:0]    i_core_sound;
	logic                i_core_sndout;
	logic [JOY_W-1:0]    i_joy1;
	logic [JOY_W-1:0]    i_joy2;
	logic [AJOY_W-1:0]   i_ajoy1;
	logic [AJOY_W-1:0]   i_ajoy2;
	logic                o_core_reset;
	logic                o_hard_reset;
	logic                o_dragon;
	logic                o_dragon64;
	logic                o_disk_cart;
	logic                o_turbo;
	logic                o_kb_coco;
	logic                o_artifact_phase;
	logic                o_artifact_en;
	logic                o_overscan;
	logic                o_dpad;
	logic                o_cas_to_core;
	logic [ADC_W-1:0]    o_adc_value;
	logic [AUDIO_W-1:0]  o_audio_l;
	logic [AUDIO_W-1:0]  o_audio_r;
	logic [12:0]         o_video_arx;
	logic [12:0]         o_video_ary;
	logic [1:0]          o_vga_sl;
	logic                o_hq2x;
	logic                o_scandoubler;
	logic [JOY_W-1:0]    o_joy1;
	logic [JOY_W-1:0]    o_joy2;
	logic [AJOY_W-1:0]   o_ajoy1;
	logic [AJOY_W-1:0]   o_ajoy2;

	int seed;
	int tests;
	int checks;
	int errors;

	// Tape window model
	logic [ADC_W-1:0]       window_model [AVG_DEPTH];
	logic [AVG_TOTAL_W-1:0] total_model;
	logic [ADC_W-1:0]       avg_model;
	logic                   tape_model;
	int                     window_ptr;
	int                     fill_count;

	coco_glue_top UUT (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Check and report helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timed out at %0t while waiting for %s", $time, what);
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests++;
		if (errors == errs_at_start)
			$display("test %-16s ok", name);
		else
			$display("test %-16s %0d errors", name, errors - errs_at_start);
	endtask

	task automatic wait_core_reset_low(input int limit);
		int cnt;
		cnt = 0;
		while (o_core_reset && cnt < limit)
		begin
			@(negedge clk_sys);
			cnt++;
		end
		if (o_core_reset)
			report_timeout("o_core_reset to fall");
	endtask

	////////////////////////////////////////
	// Machine select and reset hold
	////////////////////////////////////////

	task automatic select_machines;
		int k;
		int delay;
		int hold_len;
		logic [1:0] m;
		// Each step is a change, code 3 included
		for (k = 1; k <= 4; k++)
		begin
			m = 2'(k % 4);
			@(negedge clk_sys);
			i_status[ST_MACHINE +: 2] = m;
			@(negedge clk_sys);
			check_value("o_dragon", 32'(m != 2'd0), 32'(o_dragon));
			check_value("o_dragon64", 32'(m == 2'd2), 32'(o_dragon64));
			delay = 1;
			while (!o_core_reset && delay < 20)
			begin
				@(negedge clk_sys);
				delay++;
			end
			if (!o_core_reset)
				report_timeout("o_core_reset to rise");
			else
				check_value("o_core_reset delay", 32'(2), 32'(delay));
			hold_len = 0;
			while (o_core_reset && hold_len < 40)
			begin
				@(negedge clk_sys);
				hold_len++;
			end
			if (o_core_reset)
				report_timeout("end of the machine change hold");
			else
				check_value("o_core_reset hold", 32'(RESET_HOLD), 32'(hold_len));
		end
	endtask

	////////////////////////////////////////
	// Hard reset pulse and reset sources
	////////////////////////////////////////

	task automatic apply_reset_source(input int src, input logic exp);
		@(negedge clk_sys);
		case (src)
			0: i_status[ST_RESET] = 1'b1;
			1: i_button_reset = 1'b1;
			default:
			begin
				i_ioctl_download = 1'b1;
				i_ioctl_index = (src == 2) ? ROM_INDEX : 8'd2;
			end
		endcase
		#1;
		check_value("o_core_reset", 32'(exp), 32'(o_core_reset));
		@(negedge clk_sys);
		i_status[ST_RESET] = 1'b0;
		i_button_reset = 1'b0;
		i_ioctl_download = 1'b0;
		#1;
		check_value("o_core_reset", 32'(0), 32'(o_core_reset));
	endtask

	task automatic toggle_hard_reset;
		int delay;
		int pulses;
		@(negedge clk_sys);
		i_status[ST_HARD_RESET] = ~i_status[ST_HARD_RESET];
		delay = 0;
		while (!o_hard_reset && delay < 10)
		begin
			@(negedge clk_sys);
			delay++;
		end
		if (!o_hard_reset)
			report_timeout("o_hard_reset pulse");
		else
			check_value("o_hard_reset delay", 32'(2), 32'(delay));
		// No second pulse may follow
		pulses = 1;
		repeat (12)
		begin
			@(negedge clk_sys);
			if (o_hard_reset)
				pulses++;
		end
		check_value("o_hard_reset pulses", 32'(1), 32'(pulses));
		wait_core_reset_low(40);
		apply_reset_source(0, 1'b1);
		apply_reset_source(1, 1'b1);
		apply_reset_source(2, 1'b1);
		// Other download indexes leave the core running
		apply_reset_source(3, 1'b0);
	endtask

	////////////////////////////////////////
	// Tape detector
	////////////////////////////////////////

	task automatic feed_sample(input logic [ADC_W-1:0] value);
		logic [ADC_W-1:0] leaving;
		int value_i;
		int avg_i;
		@(negedge clk_sys);
		i_adc_data = value;
		i_adc_sync = ~i_adc_sync;
		// Oldest entry counts as zero until the window is full
		leaving = (fill_count >= AVG_DEPTH) ? window_model[window_ptr] : '0;
		total_model = total_model + AVG_TOTAL_W'(value) - AVG_TOTAL_W'(leaving);
		window_model[window_ptr] = value;
		window_ptr = (window_ptr + 1) % AVG_DEPTH;
		if (fill_count < AVG_DEPTH)
			fill_count++;
		avg_model = total_model[AVG_TOTAL_W-1:AVG_LOG2];
		value_i = int'(value);
		avg_i = int'(avg_model);
		// Low input sets the bit, high clears it, the band between holds
		if (value_i + TAPE_HYST < avg_i)
			tape_model = 1'b1;
		else if (value_i > avg_i + TAPE_HYST)
			tape_model = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_value("o_adc_value", 32'(value), 32'(o_adc_value));
		check_value("o_adc_avg", 32'(avg_model), 32'(UUT.u_adc_tape.o_adc_avg));
		check_value("o_cas_to_core", 32'(tape_model), 32'(o_cas_to_core));
	endtask

	task automatic slice_tape;
		// ADC source so the tape bit shows on the core input
		@(negedge clk_sys);
		i_status[ST_TAPE_ADC] = 1'b1;
		repeat (AVG_DEPTH) feed_sample(12'd2000);
		feed_sample(12'd1800);
		check_value("o_cas_to_core", 32'(1), 32'(o_cas_to_core));
		repeat (7) feed_sample(12'd1800);
		repeat (4) feed_sample(12'd1950);
		check_value("o_cas_to_core", 32'(1), 32'(o_cas_to_core));
		feed_sample(12'd2200);
		check_value("o_cas_to_core", 32'(0), 32'(o_cas_to_core));
		repeat (7) feed_sample(12'd2200);
		repeat (4) feed_sample(12'd1950);
		check_value("o_cas_to_core", 32'(0), 32'(o_cas_to_core));
		// Leave the bit set so the audio test hears the ADC monitor
		feed_sample(12'd1800);
	endtask

	////////////////////////////////////////
	// Audio, joysticks and video options
	////////////////////////////////////////

	task automatic mix_audio;
		int combo;
		logic sel;
		logic mon;
		logic cas_exp;
		logic [AUDIO_W-1:0] audio_exp;
		for (combo = 0; combo < 4; combo++)
		begin
			repeat (16)
			begin
				@(negedge clk_sys);
				sel = combo[0];
				mon = combo[1];
				i_status[ST_TAPE_ADC] = sel;
				i_status[ST_TAPE_MON] = mon;
				i_core_sound = SND_W'($random(seed));
				i_core_sndout = 1'($random(seed));
				i_player_bit = 1'($random(seed));
				#1;
				cas_exp = sel ? tape_model : i_player_bit;
				audio_exp = {i_core_sndout, i_core_sound[11:6],
					i_core_sound[5] ^ (mon & cas_exp), i_core_sound[4:0], 3'b000};
				check_value("o_cas_to_core", 32'(cas_exp), 32'(o_cas_to_core));
				check_value("o_audio_l", 32'(audio_exp), 32'(o_audio_l));
				check_value("o_audio_r", 32'(audio_exp), 32'(o_audio_r));
			end
		end
	endtask

	task automatic route_joysticks;
		int swap;
		logic [AJOY_W-1:0] c1;
		logic [AJOY_W-1:0] c2;
		for (swap = 0; swap < 2; swap++)
		begin
			repeat (16)
			begin
				@(negedge clk_sys);
				i_status[ST_SWAP] = swap[0];
				i_joy1 = $random(seed);
				i_joy2 = $random(seed);
				i_ajoy1 = AJOY_W'($random(seed));
				i_ajoy2 = AJOY_W'($random(seed));
				#1;
				// Adding 128 to a byte flips its top bit
				c1 = i_ajoy1 ^ 16'h8080;
				c2 = i_ajoy2 ^ 16'h8080;
				check_value("o_joy1", swap[0] ? i_joy2 : i_joy1, o_joy1);
				check_value("o_joy2", swap[0] ? i_joy1 : i_joy2, o_joy2);
				check_value("o_ajoy1", 32'(swap[0] ? c2 : c1), 32'(o_ajoy1));
				check_value("o_ajoy2", 32'(swap[0] ? c1 : c2), 32'(o_ajoy2));
			end
		end
	endtask

	task automatic decode_video;
		int ar;
		int scale;
		int f;
		for (ar = 0; ar < 4; ar++)
			for (scale = 0; scale < 8; scale++)
				for (f = 0; f < 2; f++)
				begin
					@(negedge clk_sys);
					i_status[ST_AR +: 2] = 2'(ar);
					i_status[ST_SCALE +: 3] = 3'(scale);
					i_forced_scandoubler = f[0];
					// Registered, one cycle later
					@(negedge clk_sys);
					check_value("o_video_arx", 32'((ar == 0) ? 4 : ar - 1), 32'(o_video_arx));
					check_value("o_video_ary", 32'((ar == 0) ? 3 : 0), 32'(o_video_ary));
					check_value("o_vga_sl", 32'((scale == 0) ? 0 : (scale - 1) % 4),
						32'(o_vga_sl));
					check_value("o_hq2x", 32'(scale == 1), 32'(o_hq2x));
					check_value("o_scandoubler", 32'(scale != 0 || f != 0), 32'(o_scandoubler));
				end
	endtask

	task automatic pass_menu_flags;
		logic [6:0] flags;
		repeat (16)
		begin
			@(negedge clk_sys);
			flags = 7'($random(seed));
			i_status[ST_TURBO] = flags[0];
			i_status[ST_KB_COCO] = flags[1];
			i_status[ST_ART_PHASE] = flags[2];
			i_status[ST_ART_OFF] = flags[3];
			i_status[ST_OVERSCAN] = flags[4];
			i_status[ST_DPAD] = flags[5];
			i_status[ST_DISK] = flags[6];
			#1;
			check_value("o_turbo", 32'(flags[0]), 32'(o_turbo));
			check_value("o_kb_coco", 32'(flags[1]), 32'(o_kb_coco));
			check_value("o_artifact_phase", 32'(flags[2]), 32'(o_artifact_phase));
			// Artifact colours on unless the menu turns them off
			check_value("o_artifact_en", 32'(!flags[3]), 32'(o_artifact_en));
			check_value("o_overscan", 32'(flags[4]), 32'(o_overscan));
			check_value("o_dpad", 32'(flags[5]), 32'(o_dpad));
			// Disk slot option is registered
			@(negedge clk_sys);
			check_value("o_disk_cart", 32'(flags[6]), 32'(o_disk_cart));
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int mark;
		seed = 32'h31f30a08;
		tests = 0;
		checks = 0;
		errors = 0;
		total_model = '0;
		avg_model = '0;
		tape_model = 1'b0;
		window_ptr = 0;
		fill_count = 0;
		i_reset = 1'b1;
		i_status = '0;
		i_button_reset = 1'b0;
		i_ioctl_download = 1'b0;
		i_ioctl_index = 8'd0;
		i_forced_scandoubler = 1'b0;
		i_adc_data = '0;
		i_adc_sync = 1'b0;
		i_player_bit = 1'b0;
		i_core_sound = '0;
		i_core_sndout = 1'b0;
		i_joy1 = '0;
		i_joy2 = '0;
		i_ajoy1 = '0;
		i_ajoy2 = '0;
		repeat (16) @(negedge clk_sys);
		i_reset = 1'b0;

		mark = errors;
		select_machines();
		report_test("machine select", mark);
		mark = errors;
		toggle_hard_reset();
		report_test("reset sources", mark);
		mark = errors;
		slice_tape();
		report_test("tape detector", mark);
		mark = errors;
		mix_audio();
		report_test("audio mixer", mark);
		mark = errors;
		route_joysticks();
		report_test("joysticks", mark);
		mark = errors;
		decode_video();
		report_test("video options", mark);
		mark = errors;
		pass_menu_flags();
		report_test("menu flags", mark);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hdl/coco_glue_pkg.sv
hdl/adc_tape_detector.sv
hdl/machine_config.sv
hdl/tape_audio_mixer.sv
hdl/joystick_router.sv
hdl/coco_glue_top.sv
test/coco_glue_checker.sv
test/coco_glue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the glue testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module coco_glue_tb \
	-f sources.f \
	-Mdir obj_dir -o sim_coco_glue

./obj_dir/sim_coco_glue | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
